// ==== hw/host_cfg_pkg.sv ====
`default_nettype none

package host_cfg_pkg;

	//////////////////////////////////////////////////
	// Extended-wire host protocol

	// One host pipe word and the number of data words per write
	localparam int EW_WORD_BITS = 16;
	localparam int EW_DATA_WORDS = 4;
	localparam int EW_IDX_BITS = $clog2(EW_DATA_WORDS);

	// Address word layout, bit 15 requests immediate apply
	localparam int EW_ADDR_BITS = 15;
	localparam int EW_APPLY_BIT = 15;

	// Register map
	localparam logic [EW_ADDR_BITS-1:0] ADDR_HOST_SHUTTER = 15'h10;
	localparam logic [EW_ADDR_BITS-1:0] ADDR_TRIGGER_MASK = 15'h11;
	localparam logic [EW_ADDR_BITS-1:0] ADDR_SHUTTER_DELAY = 15'h13;

	//////////////////////////////////////////////////
	// Configuration word

	localparam int CFG_WORD_BITS = EW_WORD_BITS * EW_DATA_WORDS;
	localparam int CFG_DELAY_FIELDS = 16;
	localparam int CFG_DELAY_FIELD_BITS = CFG_WORD_BITS / CFG_DELAY_FIELDS;

	// Raw register value, or one delay nibble per shutter channel
	typedef union packed {
		logic [CFG_WORD_BITS-1:0] raw;
		logic [CFG_DELAY_FIELDS-1:0][CFG_DELAY_FIELD_BITS-1:0] delay;
	} cfg_word_u;

endpackage

`default_nettype wire

// ==== hw/pulse_out_pkg.sv ====
`default_nettype none

package pulse_out_pkg;

	//////////////////////////////////////////////////
	// Shutter and trigger outputs

	localparam int NUM_CHANNELS = 16;

	// Per-channel delay in clk cycles
	localparam int DELAY_BITS = 4;
	localparam int MAX_DELAY = 15;

	//////////////////////////////////////////////////
	// Command memory geometry

	localparam int CMD_DEPTH = 256;
	localparam int CMD_ADDR_BITS = 8;
	localparam int CMD_WORD_BITS = 16;

endpackage

`default_nettype wire

// ==== hw/ewire_deserializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ewire_deserializer (
	input  wire                                      clk,
	input  wire                                      ti_reset,
	input  wire  [host_cfg_pkg::EW_WORD_BITS-1:0]    ew_data_i,
	input  wire                                      ew_write_i,
	output logic [host_cfg_pkg::EW_ADDR_BITS-1:0]    wr_addr_o,
	output host_cfg_pkg::cfg_word_u                  wr_data_o,
	output logic                                     wr_apply_now_o,
	output logic                                     wr_strobe_o
);

	import host_cfg_pkg::*;

	typedef enum logic [1:0] {
		ST_ADDR,
		ST_DATA,
		ST_DONE
	} state_t;

	state_t state;
	logic [EW_IDX_BITS-1:0] word_idx;

	// Write is complete for exactly the one cycle spent in DONE
	assign wr_strobe_o = (state == ST_DONE);

	//////////////////////////////////////////////////
	// Word sequencing

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			state <= ST_ADDR;
			word_idx <= '0;
		end else begin
			case (state)
				// A word strobed during DONE already starts the next write
				ST_ADDR, ST_DONE: begin
					word_idx <= '0;
					state <= ew_write_i ? ST_DATA : ST_ADDR;
				end
				ST_DATA: begin
					if (ew_write_i) begin
						word_idx <= word_idx + 1'b1;
						if (word_idx == EW_IDX_BITS'(EW_DATA_WORDS - 1))
							state <= ST_DONE;
					end
				end
				default: state <= ST_ADDR;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Address and data capture

	always_ff @(posedge clk) begin
		if (ew_write_i) begin
			if (state == ST_DATA) begin
				// Most significant word arrives first
				wr_data_o.raw <= {wr_data_o.raw[CFG_WORD_BITS-EW_WORD_BITS-1:0], ew_data_i};
			end else begin
				wr_addr_o <= ew_data_i[EW_ADDR_BITS-1:0];
				wr_apply_now_o <= ew_data_i[EW_APPLY_BIT];
			end
		end
	end

	// A write needs five host words, so strobes are never back to back
	a_strobe_single: assert property (@(posedge clk) disable iff (ti_reset)
		wr_strobe_o |=> !wr_strobe_o);

endmodule

`default_nettype wire

// ==== hw/ewire_register_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module ewire_register_bank (
	input  wire                                        clk,
	input  wire                                        ti_reset,
	input  wire  [host_cfg_pkg::EW_ADDR_BITS-1:0]      wr_addr_i,
	input  host_cfg_pkg::cfg_word_u                    wr_data_i,
	input  wire                                        wr_apply_now_i,
	input  wire                                        wr_strobe_i,
	input  wire                                        pp_update_i,
	output logic [pulse_out_pkg::NUM_CHANNELS-1:0]     host_shutter_o,
	output logic [pulse_out_pkg::NUM_CHANNELS-1:0]     trigger_mask_o,
	output host_cfg_pkg::cfg_word_u                    delay_o
);

	import host_cfg_pkg::*;
	import pulse_out_pkg::*;

	logic [NUM_CHANNELS-1:0] shutter_staged;
	logic [NUM_CHANNELS-1:0] mask_staged;
	cfg_word_u delay_staged;

	logic sel_shutter;
	logic sel_mask;
	logic sel_delay;

	// Registers waiting for their immediate apply, {delay, mask, shutter}
	logic [2:0] apply_pend;

	assign sel_shutter = wr_strobe_i && (wr_addr_i == ADDR_HOST_SHUTTER);
	assign sel_mask = wr_strobe_i && (wr_addr_i == ADDR_TRIGGER_MASK);
	assign sel_delay = wr_strobe_i && (wr_addr_i == ADDR_SHUTTER_DELAY);

	//////////////////////////////////////////////////
	// Staged copies

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			shutter_staged <= '0;
			mask_staged <= '0;
			delay_staged <= '0;
			apply_pend <= '0;
		end else begin
			if (sel_shutter)
				shutter_staged <= wr_data_i.raw[NUM_CHANNELS-1:0];
			if (sel_mask)
				mask_staged <= wr_data_i.raw[NUM_CHANNELS-1:0];
			if (sel_delay) begin
				// Only fields that drive a channel are kept
				for (int n = 0; n < NUM_CHANNELS; n++)
					delay_staged.delay[n] <= wr_data_i.delay[n];
			end
			apply_pend <= wr_apply_now_i ? {sel_delay, sel_mask, sel_shutter} : 3'b000;
		end
	end

	//////////////////////////////////////////////////
	// Active copies

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			host_shutter_o <= '0;
			trigger_mask_o <= '0;
			delay_o <= '0;
		end else begin
			if (pp_update_i || apply_pend[0])
				host_shutter_o <= shutter_staged;
			if (pp_update_i || apply_pend[1])
				trigger_mask_o <= mask_staged;
			if (pp_update_i || apply_pend[2])
				delay_o <= delay_staged;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cmd_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_memory (
	input  wire                                         clk,
	input  wire                                         ti_reset,
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0]     cmd_addr_i,
	input  wire                                         cmd_set_addr_i,
	input  wire                                         cmd_write_i,
	input  wire                                         cmd_read_i,
	input  wire  [pulse_out_pkg::CMD_WORD_BITS-1:0]     cmd_wdata_i,
	output logic [pulse_out_pkg::CMD_WORD_BITS-1:0]     cmd_rdata_o,
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0]     pp_cmd_addr_i,
	output logic [pulse_out_pkg::CMD_WORD_BITS-1:0]     pp_cmd_data_o
);

	import pulse_out_pkg::*;

	logic [CMD_WORD_BITS-1:0] cmd_mem [CMD_DEPTH];
	logic [CMD_ADDR_BITS-1:0] host_addr;

	//////////////////////////////////////////////////
	// Host address counter

	// Setting the address takes priority over an access in the same cycle
	always_ff @(posedge clk) begin
		if (ti_reset)
			host_addr <= '0;
		else if (cmd_set_addr_i)
			host_addr <= cmd_addr_i;
		else if (cmd_write_i || cmd_read_i)
			host_addr <= host_addr + 1'b1;
	end

	//////////////////////////////////////////////////
	// Storage and ports

	always_ff @(posedge clk) begin
		if (cmd_write_i && !cmd_set_addr_i)
			cmd_mem[host_addr] <= cmd_wdata_i;
		pp_cmd_data_o <= cmd_mem[pp_cmd_addr_i];
	end

	// Host side sees the word under the counter without latency
	assign cmd_rdata_o = cmd_mem[host_addr];

	a_no_rw_collision: assert property (@(posedge clk) disable iff (ti_reset)
		!(cmd_write_i && cmd_read_i));

endmodule

`default_nettype wire

// ==== hw/output_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module output_select (
	input  wire                                        clk,
	input  wire                                        ti_reset,
	input  wire                                        pp_active_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]     pp_shutter_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]     pp_trigger_i,
	input  wire                                        host_trigger_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]     host_shutter_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]     trigger_mask_i,
	input  host_cfg_pkg::cfg_word_u                    delay_i,
	output logic [pulse_out_pkg::NUM_CHANNELS-1:0]     shutter_o,
	output logic [pulse_out_pkg::NUM_CHANNELS-1:0]     trigger_o
);

	import host_cfg_pkg::*;
	import pulse_out_pkg::*;

	// Past MAX_DELAY samples of each sequencer shutter line, newest in bit 0
	logic [MAX_DELAY-1:0] delay_line [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] shutter_delayed;
	logic host_trig_q;

	//////////////////////////////////////////////////
	// Shutter delay lines

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			for (int n = 0; n < NUM_CHANNELS; n++)
				delay_line[n] <= '0;
		end else begin
			for (int n = 0; n < NUM_CHANNELS; n++)
				delay_line[n] <= {delay_line[n][MAX_DELAY-2:0], pp_shutter_i[n]};
		end
	end

	// Tap 0 is the live input, so the output register adds the extra cycle
	always_comb begin
		logic [MAX_DELAY:0] line;
		logic [DELAY_BITS-1:0] tap;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			line = {delay_line[n], pp_shutter_i[n]};
			tap = delay_i.delay[n];
			shutter_delayed[n] = line[tap];
		end
	end

	//////////////////////////////////////////////////
	// Output selection

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			host_trig_q <= 1'b0;
			shutter_o <= '0;
			trigger_o <= '0;
		end else begin
			host_trig_q <= host_trigger_i;
			if (pp_active_i) begin
				shutter_o <= shutter_delayed;
				trigger_o <= pp_trigger_i;
			end else begin
				shutter_o <= host_shutter_i;
				// Fire the mask once per rising edge of the host trigger
				trigger_o <= (host_trigger_i && !host_trig_q) ? trigger_mask_i : '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/pulse_host_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pulse_host_top (
	input  wire                                         clk,
	input  wire                                         ti_reset,
	// Extended-wire host stream
	input  wire  [host_cfg_pkg::EW_WORD_BITS-1:0]       ew_data_i,
	input  wire                                         ew_write_i,
	input  wire                                         pp_update_i,
	// Command memory host port
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0]     cmd_addr_i,
	input  wire                                         cmd_set_addr_i,
	input  wire                                         cmd_write_i,
	input  wire                                         cmd_read_i,
	input  wire  [pulse_out_pkg::CMD_WORD_BITS-1:0]     cmd_wdata_i,
	output wire  [pulse_out_pkg::CMD_WORD_BITS-1:0]     cmd_rdata_o,
	// Sequencer side
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0]     pp_cmd_addr_i,
	output wire  [pulse_out_pkg::CMD_WORD_BITS-1:0]     pp_cmd_data_o,
	input  wire                                         pp_active_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]      pp_shutter_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]      pp_trigger_i,
	// Outputs
	input  wire                                         host_trigger_i,
	output wire  [pulse_out_pkg::NUM_CHANNELS-1:0]      shutter_o,
	output wire  [pulse_out_pkg::NUM_CHANNELS-1:0]      trigger_o
);

	import host_cfg_pkg::*;
	import pulse_out_pkg::*;

	wire [EW_ADDR_BITS-1:0] wr_addr;
	cfg_word_u wr_data;
	wire wr_apply_now;
	wire wr_strobe;

	wire [NUM_CHANNELS-1:0] host_shutter;
	wire [NUM_CHANNELS-1:0] trigger_mask;
	cfg_word_u delay;

	ewire_deserializer u_deserializer (
		.clk            (clk),
		.ti_reset       (ti_reset),
		.ew_data_i      (ew_data_i),
		.ew_write_i     (ew_write_i),
		.wr_addr_o      (wr_addr),
		.wr_data_o      (wr_data),
		.wr_apply_now_o (wr_apply_now),
		.wr_strobe_o    (wr_strobe)
	);

	ewire_register_bank u_register_bank (
		.clk            (clk),
		.ti_reset       (ti_reset),
		.wr_addr_i      (wr_addr),
		.wr_data_i      (wr_data),
		.wr_apply_now_i (wr_apply_now),
		.wr_strobe_i    (wr_strobe),
		.pp_update_i    (pp_update_i),
		.host_shutter_o (host_shutter),
		.trigger_mask_o (trigger_mask),
		.delay_o        (delay)
	);

	cmd_memory u_cmd_memory (
		.clk            (clk),
		.ti_reset       (ti_reset),
		.cmd_addr_i     (cmd_addr_i),
		.cmd_set_addr_i (cmd_set_addr_i),
		.cmd_write_i    (cmd_write_i),
		.cmd_read_i     (cmd_read_i),
		.cmd_wdata_i    (cmd_wdata_i),
		.cmd_rdata_o    (cmd_rdata_o),
		.pp_cmd_addr_i  (pp_cmd_addr_i),
		.pp_cmd_data_o  (pp_cmd_data_o)
	);

	output_select u_output_select (
		.clk            (clk),
		.ti_reset       (ti_reset),
		.pp_active_i    (pp_active_i),
		.pp_shutter_i   (pp_shutter_i),
		.pp_trigger_i   (pp_trigger_i),
		.host_trigger_i (host_trigger_i),
		.host_shutter_i (host_shutter),
		.trigger_mask_i (trigger_mask),
		.delay_i        (delay),
		.shutter_o      (shutter_o),
		.trigger_o      (trigger_o)
	);

endmodule

`default_nettype wire

// ==== verification/pulse_host_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pulse_host_checker (
	input  wire                                     clk,
	input  wire                                     ti_reset,
	input  wire  [host_cfg_pkg::EW_WORD_BITS-1:0]   ew_data_i,
	input  wire                                     ew_write_i,
	input  wire                                     pp_update_i,
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0] cmd_addr_i,
	input  wire                                     cmd_set_addr_i,
	input  wire                                     cmd_write_i,
	input  wire                                     cmd_read_i,
	input  wire  [pulse_out_pkg::CMD_WORD_BITS-1:0] cmd_wdata_i,
	input  wire  [pulse_out_pkg::CMD_ADDR_BITS-1:0] pp_cmd_addr_i,
	input  wire                                     pp_active_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]  pp_shutter_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]  pp_trigger_i,
	input  wire                                     host_trigger_i,
	input  wire  [pulse_out_pkg::CMD_WORD_BITS-1:0] dut_cmd_rdata_i,
	input  wire  [pulse_out_pkg::CMD_WORD_BITS-1:0] dut_pp_cmd_data_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]  dut_shutter_i,
	input  wire  [pulse_out_pkg::NUM_CHANNELS-1:0]  dut_trigger_i,
	output int                                      errors_o
);

	import host_cfg_pkg::*;
	import pulse_out_pkg::*;

	int err_count = 0;
	logic check_en;

	// Host word assembly
	logic expect_data;
	int words;
	logic [EW_ADDR_BITS-1:0] addr;
	logic apply;
	logic [CFG_WORD_BITS-1:0] data;
	logic write_done;

	// Staged and active registers
	logic [NUM_CHANNELS-1:0] stg_shutter;
	logic [NUM_CHANNELS-1:0] stg_mask;
	logic [CFG_WORD_BITS-1:0] stg_delay;
	logic [NUM_CHANNELS-1:0] act_shutter;
	logic [NUM_CHANNELS-1:0] act_mask;
	logic [CFG_WORD_BITS-1:0] act_delay;
	logic [2:0] pend;

	// Shutter history, hist[0] is the sample from the previous edge
	logic [NUM_CHANNELS-1:0] hist [MAX_DELAY];
	logic host_trig_prev;
	logic [NUM_CHANNELS-1:0] exp_shutter;
	logic [NUM_CHANNELS-1:0] exp_trigger;

	// Command memory, known marks words written since reset
	logic [CMD_WORD_BITS-1:0] mem [CMD_DEPTH];
	logic known [CMD_DEPTH];
	logic [CMD_ADDR_BITS-1:0] host_addr;
	logic [CMD_WORD_BITS-1:0] exp_pp;
	logic exp_pp_known;

	assign errors_o = err_count;

	//////////////////////////////////////////////////
	// Reference model

	always @(posedge clk) begin
		int d;
		logic [NUM_CHANNELS-1:0] seq;
		check_en <= !ti_reset;
		if (ti_reset) begin
			expect_data <= 1'b0;
			words <= 0;
			write_done <= 1'b0;
			pend <= '0;
			stg_shutter <= '0;
			stg_mask <= '0;
			stg_delay <= '0;
			act_shutter <= '0;
			act_mask <= '0;
			act_delay <= '0;
			host_trig_prev <= 1'b0;
			exp_shutter <= '0;
			exp_trigger <= '0;
			host_addr <= '0;
			exp_pp_known <= 1'b0;
			for (int j = 0; j < MAX_DELAY; j++)
				hist[j] <= '0;
			for (int j = 0; j < CMD_DEPTH; j++)
				known[j] <= 1'b0;
		end else begin
			// Address word first, then four data words MSW first
			write_done <= 1'b0;
			if (ew_write_i) begin
				if (!expect_data) begin
					addr <= ew_data_i[EW_ADDR_BITS-1:0];
					apply <= ew_data_i[EW_WORD_BITS-1];
					expect_data <= 1'b1;
					words <= 0;
				end else begin
					data <= {data[CFG_WORD_BITS-EW_WORD_BITS-1:0], ew_data_i};
					words <= words + 1;
					if (words == EW_DATA_WORDS - 1) begin
						expect_data <= 1'b0;
						write_done <= 1'b1;
					end
				end
			end

			pend <= '0;
			if (write_done) begin
				if (addr == ADDR_HOST_SHUTTER)
					stg_shutter <= data[NUM_CHANNELS-1:0];
				if (addr == ADDR_TRIGGER_MASK)
					stg_mask <= data[NUM_CHANNELS-1:0];
				if (addr == ADDR_SHUTTER_DELAY)
					stg_delay <= data;
				if (apply) begin
					pend <= {addr == ADDR_SHUTTER_DELAY, addr == ADDR_TRIGGER_MASK,
						addr == ADDR_HOST_SHUTTER};
				end
			end
			if (pp_update_i || pend[0])
				act_shutter <= stg_shutter;
			if (pp_update_i || pend[1])
				act_mask <= stg_mask;
			if (pp_update_i || pend[2])
				act_delay <= stg_delay;

			// Delay d picks the sample taken d edges ago
			for (int n = 0; n < NUM_CHANNELS; n++) begin
				d = int'(act_delay[n*DELAY_BITS +: DELAY_BITS]);
				seq[n] = (d == 0) ? pp_shutter_i[n] : hist[d-1][n];
			end
			hist[0] <= pp_shutter_i;
			for (int j = 1; j < MAX_DELAY; j++)
				hist[j] <= hist[j-1];

			host_trig_prev <= host_trigger_i;
			if (pp_active_i) begin
				exp_shutter <= seq;
				exp_trigger <= pp_trigger_i;
			end else begin
				exp_shutter <= act_shutter;
				exp_trigger <= (host_trigger_i && !host_trig_prev) ? act_mask : '0;
			end

			if (cmd_set_addr_i)
				host_addr <= cmd_addr_i;
			else if (cmd_write_i || cmd_read_i)
				host_addr <= host_addr + 8'd1;
			if (cmd_write_i && !cmd_set_addr_i) begin
				mem[host_addr] <= cmd_wdata_i;
				known[host_addr] <= 1'b1;
			end
			exp_pp <= mem[pp_cmd_addr_i];
			exp_pp_known <= known[pp_cmd_addr_i];
		end
	end

	//////////////////////////////////////////////////
	// Comparison, on the falling edge where outputs are settled

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
			err_count++;
		end
	endtask

	always @(negedge clk) begin
		if (check_en) begin
			compare("shutter_o", 32'(dut_shutter_i), 32'(exp_shutter));
			compare("trigger_o", 32'(dut_trigger_i), 32'(exp_trigger));
			if (known[host_addr])
				compare("cmd_rdata_o", 32'(dut_cmd_rdata_i), 32'(mem[host_addr]));
			if (exp_pp_known)
				compare("pp_cmd_data_o", 32'(dut_pp_cmd_data_i), 32'(exp_pp));
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_pulse_host.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pulse_host;

	import host_cfg_pkg::*;
	import pulse_out_pkg::*;

	logic clk;
	logic ti_reset;
	logic [EW_WORD_BITS-1:0] ew_data_i;
	logic ew_write_i;
	logic pp_update_i;
	logic [CMD_ADDR_BITS-1:0] cmd_addr_i;
	logic cmd_set_addr_i;
	logic cmd_write_i;
	logic cmd_read_i;
	logic [CMD_WORD_BITS-1:0] cmd_wdata_i;
	logic [CMD_ADDR_BITS-1:0] pp_cmd_addr_i;
	logic pp_active_i;
	logic [NUM_CHANNELS-1:0] pp_shutter_i;
	logic [NUM_CHANNELS-1:0] pp_trigger_i;
	logic host_trigger_i;
	wire [CMD_WORD_BITS-1:0] cmd_rdata_o;
	wire [CMD_WORD_BITS-1:0] pp_cmd_data_o;
	wire [NUM_CHANNELS-1:0] shutter_o;
	wire [NUM_CHANNELS-1:0] trigger_o;

	int checker_errors;
	int fail_count;
	int test_count;
	int errors_before;
	logic [31:0] lcg_state;

	pulse_host_top pulse_host_top_i (
		.clk            (clk),
		.ti_reset       (ti_reset),
		.ew_data_i      (ew_data_i),
		.ew_write_i     (ew_write_i),
		.pp_update_i    (pp_update_i),
		.cmd_addr_i     (cmd_addr_i),
		.cmd_set_addr_i (cmd_set_addr_i),
		.cmd_write_i    (cmd_write_i),
		.cmd_read_i     (cmd_read_i),
		.cmd_wdata_i    (cmd_wdata_i),
		.cmd_rdata_o    (cmd_rdata_o),
		.pp_cmd_addr_i  (pp_cmd_addr_i),
		.pp_cmd_data_o  (pp_cmd_data_o),
		.pp_active_i    (pp_active_i),
		.pp_shutter_i   (pp_shutter_i),
		.pp_trigger_i   (pp_trigger_i),
		.host_trigger_i (host_trigger_i),
		.shutter_o      (shutter_o),
		.trigger_o      (trigger_o)
	);

	pulse_host_checker u_checker (
		.clk               (clk),
		.ti_reset          (ti_reset),
		.ew_data_i         (ew_data_i),
		.ew_write_i        (ew_write_i),
		.pp_update_i       (pp_update_i),
		.cmd_addr_i        (cmd_addr_i),
		.cmd_set_addr_i    (cmd_set_addr_i),
		.cmd_write_i       (cmd_write_i),
		.cmd_read_i        (cmd_read_i),
		.cmd_wdata_i       (cmd_wdata_i),
		.pp_cmd_addr_i     (pp_cmd_addr_i),
		.pp_active_i       (pp_active_i),
		.pp_shutter_i      (pp_shutter_i),
		.pp_trigger_i      (pp_trigger_i),
		.host_trigger_i    (host_trigger_i),
		.dut_cmd_rdata_i   (cmd_rdata_o),
		.dut_pp_cmd_data_i (pp_cmd_data_o),
		.dut_shutter_i     (shutter_o),
		.dut_trigger_i     (trigger_o),
		.errors_o          (checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers, all start and end just after a falling edge

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper halves only, the low LCG bits repeat too quickly
	function automatic logic [CFG_WORD_BITS-1:0] random_word64();
		logic [CFG_WORD_BITS-1:0] w;
		logic [31:0] r;
		w = '0;
		for (int i = 0; i < EW_DATA_WORDS; i++) begin
			r = next_random();
			w = {w[CFG_WORD_BITS-EW_WORD_BITS-1:0], r[31:16]};
		end
		return w;
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	task automatic send_word(input logic [EW_WORD_BITS-1:0] word);
		ew_data_i = word;
		ew_write_i = 1'b1;
		@(negedge clk);
		ew_write_i = 1'b0;
	endtask

	task automatic write_reg(input logic [EW_ADDR_BITS-1:0] addr,
			input logic [CFG_WORD_BITS-1:0] value, input logic apply);
		send_word({apply, addr});
		for (int i = EW_DATA_WORDS - 1; i >= 0; i--)
			send_word(value[i*EW_WORD_BITS +: EW_WORD_BITS]);
	endtask

	task automatic set_cmd_addr(input logic [CMD_ADDR_BITS-1:0] addr);
		cmd_addr_i = addr;
		cmd_set_addr_i = 1'b1;
		@(negedge clk);
		cmd_set_addr_i = 1'b0;
	endtask

	task automatic wait_for_shutter(input logic [NUM_CHANNELS-1:0] value);
		int waited;
		waited = 0;
		while (shutter_o !== value && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (shutter_o !== value) begin
			$display("Timeout: shutter_o never showed the written host shutter value");
			fail_count++;
		end
	endtask

	task automatic pulse_trigger(input logic [NUM_CHANNELS-1:0] mask);
		int waited;
		host_trigger_i = 1'b1;
		@(negedge clk);
		host_trigger_i = 1'b0;
		waited = 0;
		while (trigger_o !== mask && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (trigger_o !== mask) begin
			$display("Timeout: trigger_o never fired the trigger mask after a host trigger");
			fail_count++;
		end
		idle(2);
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = checker_errors + fail_count - errors_before;
		test_count++;
		$display("Test %0d %s finished with %0d errors", test_count, name, errs);
		errors_before = checker_errors + fail_count;
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] r;
		logic [CFG_WORD_BITS-1:0] cfg;
		logic [NUM_CHANNELS-1:0] shutter_val;
		logic [NUM_CHANNELS-1:0] mask_val;
		logic [CMD_ADDR_BITS-1:0] start;
		lcg_state = 32'd62;
		fail_count = 0;
		test_count = 0;
		errors_before = 0;
		ti_reset = 1'b1;
		ew_data_i = '0;
		ew_write_i = 1'b0;
		pp_update_i = 1'b0;
		cmd_addr_i = '0;
		cmd_set_addr_i = 1'b0;
		cmd_write_i = 1'b0;
		cmd_read_i = 1'b0;
		cmd_wdata_i = '0;
		pp_cmd_addr_i = '0;
		pp_active_i = 1'b0;
		pp_shutter_i = '0;
		pp_trigger_i = '0;
		host_trigger_i = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		ti_reset = 1'b0;

		idle(4);
		finish_test("reset values");

		// Mask goes first so it is active once the shutter shows up
		for (int i = 0; i < 6; i++) begin
			cfg = random_word64();
			cfg[0] = 1'b1;
			mask_val = cfg[NUM_CHANNELS-1:0];
			write_reg(ADDR_TRIGGER_MASK, cfg, 1'b1);
			cfg = random_word64();
			shutter_val = cfg[NUM_CHANNELS-1:0];
			write_reg(ADDR_HOST_SHUTTER, cfg, 1'b1);
			wait_for_shutter(shutter_val);
			pulse_trigger(mask_val);
		end
		finish_test("immediate host writes");

		for (int i = 0; i < 4; i++) begin
			cfg = random_word64();
			if (cfg[NUM_CHANNELS-1:0] == shutter_o)
				cfg[0] = ~cfg[0];
			shutter_val = cfg[NUM_CHANNELS-1:0];
			write_reg(ADDR_HOST_SHUTTER, cfg, 1'b0);
			cfg = random_word64();
			cfg[1] = 1'b1;
			mask_val = cfg[NUM_CHANNELS-1:0];
			write_reg(ADDR_TRIGGER_MASK, cfg, 1'b0);
			idle(6);
			pp_update_i = 1'b1;
			@(negedge clk);
			pp_update_i = 1'b0;
			wait_for_shutter(shutter_val);
			pulse_trigger(mask_val);
		end
		finish_test("staged writes and update");

		write_reg(ADDR_SHUTTER_DELAY, random_word64(), 1'b1);
		// Unmapped address, nothing may change
		write_reg(15'h12, random_word64(), 1'b1);
		idle(3);
		pp_active_i = 1'b1;
		for (int i = 0; i < 80; i++) begin
			r = next_random();
			pp_shutter_i = r[31:16];
			r = next_random();
			pp_trigger_i = r[31:16];
			@(negedge clk);
		end
		pp_active_i = 1'b0;
		pp_shutter_i = '0;
		pp_trigger_i = '0;
		idle(2);
		finish_test("sequencer delays");

		// Start near the top so the counter wraps
		r = next_random();
		start = CMD_ADDR_BITS'(CMD_DEPTH - 20 + int'(r[19:16]));
		set_cmd_addr(start);
		for (int i = 0; i < 48; i++) begin
			r = next_random();
			cmd_wdata_i = r[31:16];
			cmd_write_i = 1'b1;
			@(negedge clk);
		end
		cmd_write_i = 1'b0;
		set_cmd_addr(start);
		for (int i = 0; i < 48; i++) begin
			cmd_read_i = 1'b1;
			@(negedge clk);
		end
		cmd_read_i = 1'b0;
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			pp_cmd_addr_i = start + CMD_ADDR_BITS'(r[31:16] % 16'd48);
			@(negedge clk);
		end
		idle(2);
		finish_test("command memory");

		$display("Tests %0d, checker errors %0d, other failures %0d",
			test_count, checker_errors, fail_count);
		if (checker_errors == 0 && fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/host_cfg_pkg.sv
hw/pulse_out_pkg.sv
hw/ewire_deserializer.sv
hw/ewire_register_bank.sv
hw/cmd_memory.sv
hw/output_select.sv
hw/pulse_host_top.sv
verification/pulse_host_checker.sv
verification/tb_pulse_host.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       = tb_pulse_host
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
